// ==== rtl/mesh_pkg.sv ====
//##########################################################
// mesh packet format
// field positions and widths shared by the decode stage,
// the request builder and the output stage
// packet is {srcaddr, data, dstaddr, ctrlmode, datamode, write}
//##########################################################

package mesh_pkg;

   // fixed low fields
   localparam int WRITE_LSB    = 0;   // 1 = write, 0 = read request
   localparam int DATAMODE_LSB = 1;
   localparam int DATAMODE_W   = 2;   // 8/16/32/64 bit transfer
   localparam int CTRLMODE_LSB = 3;
   localparam int CTRLMODE_W   = 5;
   localparam int DSTADDR_LSB  = 8;   // first AW wide field

   // data follows dstaddr
   function automatic int data_lsb(input int aw);
      return DSTADDR_LSB + aw;
   endfunction

   // return address sits on top
   function automatic int srcaddr_lsb(input int aw);
      return DSTADDR_LSB + 2 * aw;
   endfunction

   // full packet width, 104 bits at aw of 32
   function automatic int pw(input int aw);
      return DSTADDR_LSB + 3 * aw;
   endfunction

endpackage

// ==== rtl/dma_pkg.sv ====
//##########################################################
// dma register map and sequencer encoding
// register index is taken from dstaddr[6:2] of a
// config packet
//##########################################################

package dma_pkg;

   //##########################################################
   // register word indices
   //##########################################################
   localparam logic [4:0] REG_CONFIG    = 5'd0;
   localparam logic [4:0] REG_STRIDE    = 5'd1;   // {dst stride, src stride}
   localparam logic [4:0] REG_COUNT     = 5'd2;
   localparam logic [4:0] REG_SRCADDR   = 5'd3;   // low half
   localparam logic [4:0] REG_SRCADDR64 = 5'd4;   // high half
   localparam logic [4:0] REG_DSTADDR   = 5'd5;
   localparam logic [4:0] REG_DSTADDR64 = 5'd6;
   localparam logic [4:0] REG_STATUS    = 5'd7;   // read only, live state

   //##########################################################
   // config bits
   //##########################################################
   localparam int CFG_ENABLE       = 0;
   localparam int CFG_IRQMODE      = 4;   // irq on done
   localparam int CFG_DATAMODE_LSB = 5;   // bits 6:5

   // sequencer state
   typedef enum logic [3:0] {
      ST_IDLE   = 4'd0,
      ST_ACTIVE = 4'd1,
      ST_DONE   = 4'd2
   } state_t;

endpackage

// ==== rtl/mesh_decode.sv ====
//##########################################################
// mesh packet field decoder
// pure slicing, no state
//##########################################################

module mesh_decode #(
   parameter  int AW = 32,
   localparam int PW = mesh_pkg::pw(AW)
) (
   input  logic [PW-1:0] packet_in,
   output logic          write_in,
   output logic [1:0]    datamode_in,
   output logic [4:0]    ctrlmode_in,
   output logic [AW-1:0] dstaddr_in,
   output logic [AW-1:0] data_in,
   output logic [AW-1:0] srcaddr_in
);

   localparam int DATA_LSB = mesh_pkg::data_lsb(AW);
   localparam int SRC_LSB  = mesh_pkg::srcaddr_lsb(AW);

   assign write_in    = packet_in[mesh_pkg::WRITE_LSB];
   assign datamode_in = packet_in[mesh_pkg::DATAMODE_LSB +: mesh_pkg::DATAMODE_W];
   assign ctrlmode_in = packet_in[mesh_pkg::CTRLMODE_LSB +: mesh_pkg::CTRLMODE_W];

   // the three address wide fields
   assign dstaddr_in  = packet_in[mesh_pkg::DSTADDR_LSB +: AW];
   assign data_in     = packet_in[DATA_LSB +: AW];
   assign srcaddr_in  = packet_in[SRC_LSB +: AW];   // readback return address

endmodule

// ==== rtl/dma_regs.sv ====
//##########################################################
// dma register block
// config packets write registers or request a readback,
// the engine writes count and cursors back after each step
// readback leaves as a pulse toward the output stage
//##########################################################

module dma_regs #(
   parameter  int          AW      = 32,
   parameter  logic [31:0] DEF_CFG = 32'h0,
   localparam int          PW      = mesh_pkg::pw(AW)
) (
   input  logic            clk,
   input  logic            nreset,
   input  logic            reg_access_in,
   input  logic [PW-1:0]   reg_packet_in,
   input  logic            reg_wait_out,   // output stage full and stalled
   input  logic            update,         // engine step taken
   input  logic [31:0]     count_next,
   input  logic [AW-1:0]   srcaddr_next,
   input  logic [AW-1:0]   dstaddr_next,
   input  dma_pkg::state_t dma_state,
   output logic            dma_en,
   output logic            irqmode,
   output logic [1:0]      datamode,
   output logic [31:0]     stride_reg,
   output logic [31:0]     count_reg,
   output logic [AW-1:0]   srcaddr_reg,
   output logic [AW-1:0]   dstaddr_reg,
   output logic            irq,
   output logic            config_write,
   output logic            rd_valid,
   output logic [AW-1:0]   rd_data,
   output logic [AW-1:0]   rd_return
);

   logic          write_in;
   logic [AW-1:0] dstaddr_in;
   logic [AW-1:0] data_in;
   logic [AW-1:0] srcaddr_in;
   logic [4:0]    reg_idx;
   logic          accept;
   logic          reg_write;
   logic          count_write;
   logic          stride_write;
   logic [31:0]   config_q;
   logic [63:0]   src_q;         // both halves always stored
   logic [63:0]   dst_q;
   logic [31:0]   rd_word;

   mesh_decode #(.AW(AW)) u_decode (
      .packet_in   (reg_packet_in),
      .write_in    (write_in),
      .datamode_in (),
      .ctrlmode_in (),
      .dstaddr_in  (dstaddr_in),
      .data_in     (data_in),
      .srcaddr_in  (srcaddr_in)
   );

   //##########################################################
   // access decode
   //##########################################################
   assign reg_idx      = dstaddr_in[6:2];
   assign accept       = reg_access_in & ~reg_wait_out;
   assign reg_write    = accept & write_in;
   assign rd_valid     = accept & ~write_in;   // one cycle pulse
   assign config_write = reg_write & (reg_idx == dma_pkg::REG_CONFIG);
   assign stride_write = reg_write & (reg_idx == dma_pkg::REG_STRIDE);
   assign count_write  = reg_write & (reg_idx == dma_pkg::REG_COUNT);

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         config_q  <= DEF_CFG;
         count_reg <= 32'd0;
      end else begin
         if (config_write)
            config_q <= data_in[31:0];
         if (count_write)
            count_reg <= data_in[31:0];
         else if (update)
            count_reg <= count_next;   // engine decrement
      end
   end

   always_ff @(posedge clk) begin
      if (stride_write)
         stride_reg <= data_in[31:0];
   end

   // cursors, register writes win over the engine
   always_ff @(posedge clk) begin
      if (reg_write && reg_idx == dma_pkg::REG_SRCADDR)
         src_q[31:0] <= data_in[31:0];
      else if (reg_write && reg_idx == dma_pkg::REG_SRCADDR64)
         src_q[63:32] <= data_in[31:0];
      else if (update)
         src_q[AW-1:0] <= srcaddr_next;
      if (reg_write && reg_idx == dma_pkg::REG_DSTADDR)
         dst_q[31:0] <= data_in[31:0];
      else if (reg_write && reg_idx == dma_pkg::REG_DSTADDR64)
         dst_q[63:32] <= data_in[31:0];
      else if (update)
         dst_q[AW-1:0] <= dstaddr_next;
   end

   assign dma_en      = config_q[dma_pkg::CFG_ENABLE];
   assign irqmode     = config_q[dma_pkg::CFG_IRQMODE];
   assign datamode    = config_q[dma_pkg::CFG_DATAMODE_LSB +: 2];
   assign srcaddr_reg = src_q[AW-1:0];
   assign dstaddr_reg = dst_q[AW-1:0];
   assign irq         = (dma_state == dma_pkg::ST_DONE) & irqmode;

   //##########################################################
   // readback
   //##########################################################
   always_comb begin
      case (reg_idx)
         dma_pkg::REG_CONFIG:    rd_word = config_q;
         dma_pkg::REG_STRIDE:    rd_word = stride_reg;
         dma_pkg::REG_COUNT:     rd_word = count_reg;
         dma_pkg::REG_SRCADDR:   rd_word = src_q[31:0];
         dma_pkg::REG_SRCADDR64: rd_word = src_q[63:32];
         dma_pkg::REG_DSTADDR:   rd_word = dst_q[31:0];
         dma_pkg::REG_DSTADDR64: rd_word = dst_q[63:32];
         dma_pkg::REG_STATUS:    rd_word = {28'd0, dma_state};   // live state
         default:                rd_word = 32'd0;
      endcase
   end

   assign rd_data   = AW'(rd_word);
   assign rd_return = srcaddr_in;   // response goes back to requester

   // count is never reprogrammed under a running step
   a_no_count_clash: assert property (@(posedge clk) disable iff (!nreset)
      !(update && count_write));

endmodule

// ==== rtl/dma_engine.sv ====
//##########################################################
// dma sequencer
// one read request per count step, source cursor as the
// read address and destination cursor as the return address
//##########################################################

module dma_engine #(
   parameter  int AW = 32,
   localparam int PW = mesh_pkg::pw(AW)
) (
   input  logic            clk,
   input  logic            nreset,
   input  logic            dma_en,
   input  logic [1:0]      datamode,
   input  logic [31:0]     stride_reg,     // {dst, src}
   input  logic [31:0]     count_reg,
   input  logic [AW-1:0]   srcaddr_reg,
   input  logic [AW-1:0]   dstaddr_reg,
   input  logic            eng_wait,
   input  logic            config_write,
   output logic            eng_valid,
   output logic [PW-1:0]   eng_packet,
   output logic            update,
   output logic [31:0]     count_next,
   output logic [AW-1:0]   srcaddr_next,
   output logic [AW-1:0]   dstaddr_next,
   output dma_pkg::state_t dma_state
);

   dma_pkg::state_t state_nxt;

   //##########################################################
   // state machine
   //##########################################################
   always_comb begin
      state_nxt = dma_state;
      case (dma_state)
         dma_pkg::ST_IDLE:
            if (dma_en && count_reg != 32'd0)
               state_nxt = dma_pkg::ST_ACTIVE;
         dma_pkg::ST_ACTIVE:
            if (update && count_reg == 32'd1)   // last step going out
               state_nxt = dma_pkg::ST_DONE;
         dma_pkg::ST_DONE:
            if (config_write)
               state_nxt = dma_pkg::ST_IDLE;   // rearm, drops irq
         default:
            state_nxt = dma_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         dma_state <= dma_pkg::ST_IDLE;
      else
         dma_state <= state_nxt;
   end

   assign eng_valid = (dma_state == dma_pkg::ST_ACTIVE);
   assign update    = eng_valid & ~eng_wait;   // request taken this edge

   // next cursors, strides zero extended
   assign count_next   = count_reg - 32'd1;
   assign srcaddr_next = srcaddr_reg + {{(AW-16){1'b0}}, stride_reg[15:0]};
   assign dstaddr_next = dstaddr_reg + {{(AW-16){1'b0}}, stride_reg[31:16]};

   //##########################################################
   // read request, ctrlmode and data stay zero
   //##########################################################
   always_comb begin
      eng_packet = '0;
      eng_packet[mesh_pkg::DATAMODE_LSB +: mesh_pkg::DATAMODE_W] = datamode;
      eng_packet[mesh_pkg::DSTADDR_LSB +: AW] = srcaddr_reg;
      eng_packet[mesh_pkg::srcaddr_lsb(AW) +: AW] = dstaddr_reg;
   end

   a_active_count: assert property (@(posedge clk) disable iff (!nreset)
      (dma_state == dma_pkg::ST_ACTIVE) |-> (count_reg != 32'd0));

   // a stalled request is held unchanged until taken
   a_req_hold: assert property (@(posedge clk) disable iff (!nreset)
      (eng_valid && eng_wait) |=> (eng_valid && $stable(eng_packet)));

endmodule

// ==== rtl/mesh_issue.sv ====
//##########################################################
// one entry output stage
// readback responses win over engine requests, the held
// packet stays put while the receiver stalls
//##########################################################

module mesh_issue #(
   parameter  int AW = 32,
   localparam int PW = mesh_pkg::pw(AW)
) (
   input  logic          clk,
   input  logic          nreset,
   input  logic          rd_valid,
   input  logic [AW-1:0] rd_data,
   input  logic [AW-1:0] rd_return,
   input  logic          eng_valid,
   input  logic [PW-1:0] eng_packet,
   input  logic          wait_in,
   output logic          access_out,
   output logic [PW-1:0] packet_out,
   output logic          eng_wait,
   output logic          reg_wait_out
);

   logic          free;         // empty, or item leaves this edge
   logic [PW-1:0] rd_packet;

   assign free         = ~access_out | ~wait_in;
   assign reg_wait_out = ~free;
   assign eng_wait     = ~free | rd_valid;   // readback has priority

   // response is a write back to the requester
   always_comb begin
      rd_packet = '0;
      rd_packet[mesh_pkg::WRITE_LSB] = 1'b1;
      rd_packet[mesh_pkg::DATAMODE_LSB +: mesh_pkg::DATAMODE_W] =
         (AW == 64) ? 2'b11 : 2'b10;
      rd_packet[mesh_pkg::DSTADDR_LSB +: AW]  = rd_return;
      rd_packet[mesh_pkg::data_lsb(AW) +: AW] = rd_data;
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         access_out <= 1'b0;
      else if (free)
         access_out <= rd_valid | eng_valid;
   end

   always_ff @(posedge clk) begin
      if (free && rd_valid)
         packet_out <= rd_packet;
      else if (free && eng_valid)
         packet_out <= eng_packet;
   end

   // a readback is only offered when the stage can take it
   a_rd_taken: assert property (@(posedge clk) disable iff (!nreset)
      rd_valid |-> free);

endmodule

// ==== rtl/dma_top.sv ====
//##########################################################
// single channel dma on the mesh packet interface
// config packets in on reg_*, requests and readbacks out
// on access_out/packet_out, irq at end of transfer
//##########################################################

module dma_top #(
   parameter  int          AW      = 32,
   parameter  logic [31:0] DEF_CFG = 32'h0,
   localparam int          PW      = mesh_pkg::pw(AW)
) (
   input  logic          clk,
   input  logic          nreset,
   input  logic          reg_access_in,
   input  logic [PW-1:0] reg_packet_in,
   output logic          reg_wait_out,
   output logic          access_out,
   output logic [PW-1:0] packet_out,
   input  logic          wait_in,
   output logic          irq
);

   logic            dma_en;
   logic [1:0]      datamode;
   logic [31:0]     stride_reg;
   logic [31:0]     count_reg;
   logic [AW-1:0]   srcaddr_reg;
   logic [AW-1:0]   dstaddr_reg;
   logic            config_write;
   logic            update;
   logic [31:0]     count_next;
   logic [AW-1:0]   srcaddr_next;
   logic [AW-1:0]   dstaddr_next;
   dma_pkg::state_t dma_state;
   logic            rd_valid;
   logic [AW-1:0]   rd_data;
   logic [AW-1:0]   rd_return;
   logic            eng_valid;
   logic [PW-1:0]   eng_packet;
   logic            eng_wait;

   dma_regs #(.AW(AW), .DEF_CFG(DEF_CFG)) u_regs (
      .clk           (clk),
      .nreset        (nreset),
      .reg_access_in (reg_access_in),
      .reg_packet_in (reg_packet_in),
      .reg_wait_out  (reg_wait_out),
      .update        (update),
      .count_next    (count_next),
      .srcaddr_next  (srcaddr_next),
      .dstaddr_next  (dstaddr_next),
      .dma_state     (dma_state),
      .dma_en        (dma_en),
      .irqmode       (),             // only feeds irq inside
      .datamode      (datamode),
      .stride_reg    (stride_reg),
      .count_reg     (count_reg),
      .srcaddr_reg   (srcaddr_reg),
      .dstaddr_reg   (dstaddr_reg),
      .irq           (irq),
      .config_write  (config_write),
      .rd_valid      (rd_valid),
      .rd_data       (rd_data),
      .rd_return     (rd_return)
   );

   dma_engine #(.AW(AW)) u_engine (
      .clk          (clk),
      .nreset       (nreset),
      .dma_en       (dma_en),
      .datamode     (datamode),
      .stride_reg   (stride_reg),
      .count_reg    (count_reg),
      .srcaddr_reg  (srcaddr_reg),
      .dstaddr_reg  (dstaddr_reg),
      .eng_wait     (eng_wait),
      .config_write (config_write),
      .eng_valid    (eng_valid),
      .eng_packet   (eng_packet),
      .update       (update),
      .count_next   (count_next),
      .srcaddr_next (srcaddr_next),
      .dstaddr_next (dstaddr_next),
      .dma_state    (dma_state)
   );

   mesh_issue #(.AW(AW)) u_issue (
      .clk          (clk),
      .nreset       (nreset),
      .rd_valid     (rd_valid),
      .rd_data      (rd_data),
      .rd_return    (rd_return),
      .eng_valid    (eng_valid),
      .eng_packet   (eng_packet),
      .wait_in      (wait_in),
      .access_out   (access_out),
      .packet_out   (packet_out),
      .eng_wait     (eng_wait),
      .reg_wait_out (reg_wait_out)
   );

endmodule

// ==== dv/dma_tb.sv ====
//##########################################################
// directed testbench for the dma top level
// config packets go in on the falling edge, every accepted
// output packet is compared with an expected queue
// build from compile.f with dma_tb as the top module
//##########################################################

module dma_tb;

   localparam int          AW       = 32;
   localparam logic [31:0] DEF_CFG  = 32'h0;
   localparam int          PW       = mesh_pkg::DSTADDR_LSB + 3 * AW;   // 104 bits
   localparam int          DATA_LSB = mesh_pkg::DSTADDR_LSB + AW;
   localparam int          SRC_LSB  = mesh_pkg::DSTADDR_LSB + 2 * AW;
   localparam int          LIMIT    = 2000;    // cycles per wait loop
   localparam logic [1:0]  DM_WORD  = 2'b10;   // 32 bit transfer

   logic          clk;
   logic          nreset;
   logic          reg_access_in;
   logic [PW-1:0] reg_packet_in;
   logic          reg_wait_out;
   logic          access_out;
   logic [PW-1:0] packet_out;
   logic          wait_in;
   logic          irq;

   logic [PW-1:0] req_q[$];   // expected engine requests, in order
   logic [PW-1:0] rsp_q[$];   // expected readbacks
   logic [31:0]   lcg_state;
   logic          bp_on;      // random wait_in when set
   int            errors;
   int            checks;
   int            reads;

   dma_top #(.AW(AW), .DEF_CFG(DEF_CFG)) u_dut (
      .clk           (clk),
      .nreset        (nreset),
      .reg_access_in (reg_access_in),
      .reg_packet_in (reg_packet_in),
      .reg_wait_out  (reg_wait_out),
      .access_out    (access_out),
      .packet_out    (packet_out),
      .wait_in       (wait_in),
      .irq           (irq)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //##########################################################
   // helpers
   //##########################################################
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // mesh packet from its fields, ctrlmode always zero
   function automatic logic [PW-1:0] make_packet(input logic wr, input logic [1:0] dm,
         input logic [AW-1:0] dst, input logic [AW-1:0] data, input logic [AW-1:0] src);
      logic [PW-1:0] p;
      p = '0;
      p[mesh_pkg::WRITE_LSB] = wr;
      p[mesh_pkg::DATAMODE_LSB +: 2] = dm;
      p[mesh_pkg::DSTADDR_LSB +: AW] = dst;
      p[DATA_LSB +: AW] = data;
      p[SRC_LSB +: AW] = src;
      return p;
   endfunction

   function automatic logic [AW-1:0] reg_addr(input logic [4:0] idx);
      return {{(AW-7){1'b0}}, idx, 2'b00};   // word index to byte address
   endfunction

   task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      errors++;
      $display("timeout at %0t while waiting for %s", $time, what);
      $display("checks %0d, errors %0d", checks, errors);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   // hold the strobe until an edge with reg_wait_out low
   task automatic send_access(input logic [PW-1:0] pkt);
      int   n;
      logic taken;
      n = 0;
      taken = 1'b0;
      @(negedge clk);
      reg_access_in = 1'b1;
      reg_packet_in = pkt;
      while (!taken && n < LIMIT) begin
         @(posedge clk);
         taken = ~reg_wait_out;   // value seen by this edge
         n++;
      end
      @(negedge clk);
      reg_access_in = 1'b0;
      if (!taken)
         abort_on_timeout("reg_wait_out to drop");
   endtask

   task automatic drain_responses();
      int n;
      n = 0;
      while (rsp_q.size() != 0 && n < LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (rsp_q.size() != 0)
         abort_on_timeout("a readback response");
   endtask

   task automatic drain_requests();
      int n;
      n = 0;
      while (req_q.size() != 0 && n < LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (req_q.size() != 0)
         abort_on_timeout("the engine read requests");
   endtask

   task automatic await_irq();
      int n;
      n = 0;
      while (!irq && n < LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!irq)
         abort_on_timeout("irq to rise");
   endtask

   task automatic reg_write(input logic [4:0] idx, input logic [31:0] val);
      send_access(make_packet(1'b1, DM_WORD, reg_addr(idx), val, '0));
   endtask

   // each read gets its own return address
   task automatic reg_read(input logic [4:0] idx, input logic [31:0] exp);
      logic [AW-1:0] ret;
      ret = 32'h8000_0000 | (AW'(reads) << 4);
      reads++;
      rsp_q.push_back(make_packet(1'b1, DM_WORD, ret, exp, '0));
      send_access(make_packet(1'b0, DM_WORD, reg_addr(idx), '0, ret));
      drain_responses();
   endtask

   // request k reads src + k*sstride, returns to dst + k*dstride
   task automatic run_transfer(input int n, input logic [AW-1:0] src,
         input logic [AW-1:0] dst, input logic [31:0] stride, input logic [31:0] cfg);
      reg_write(dma_pkg::REG_CONFIG, 32'h0);   // back to idle, engine off
      reg_write(dma_pkg::REG_COUNT, 32'(n));
      reg_write(dma_pkg::REG_SRCADDR, src);
      reg_write(dma_pkg::REG_DSTADDR, dst);
      reg_write(dma_pkg::REG_STRIDE, stride);
      for (int k = 0; k < n; k++)
         req_q.push_back(make_packet(1'b0, cfg[dma_pkg::CFG_DATAMODE_LSB +: 2],
            src + AW'(k) * AW'(stride[15:0]), '0, dst + AW'(k) * AW'(stride[31:16])));
      reg_write(dma_pkg::REG_CONFIG, cfg);   // go
   endtask

   task automatic check_final(input int n, input logic [AW-1:0] src,
         input logic [AW-1:0] dst, input logic [31:0] stride);
      reg_read(dma_pkg::REG_COUNT, 32'h0);
      reg_read(dma_pkg::REG_STATUS, 32'(dma_pkg::ST_DONE));
      reg_read(dma_pkg::REG_SRCADDR, src + AW'(n) * AW'(stride[15:0]));
      reg_read(dma_pkg::REG_DSTADDR, dst + AW'(n) * AW'(stride[31:16]));
   endtask

   //##########################################################
   // output monitor and wait_in pattern
   //##########################################################
   task automatic collect_packets();
      forever begin
         @(posedge clk);
         if (nreset && access_out && !wait_in) begin   // packet taken here
            if (packet_out[mesh_pkg::WRITE_LSB] && rsp_q.size() == 0) begin
               errors++;
               $display("unexpected readback response at %0t", $time);
            end else if (packet_out[mesh_pkg::WRITE_LSB]) begin
               check(128'(packet_out), 128'(rsp_q.pop_front()), "readback response");
            end else if (req_q.size() == 0) begin
               errors++;
               $display("unexpected engine request at %0t", $time);
            end else begin
               check(128'(packet_out), 128'(req_q.pop_front()), "engine request");
            end
         end
      end
   endtask

   task automatic drive_wait();
      logic [31:0] rnd;
      forever begin
         @(negedge clk);
         rnd = lcg_next();
         wait_in = bp_on & rnd[16];   // about half the cycles stalled
      end
   endtask

   //##########################################################
   // tests
   //##########################################################
   task automatic reset_values();
      check(128'(access_out), 128'(1'b0), "access_out after reset");
      check(128'(irq), 128'(1'b0), "irq after reset");
      reg_read(dma_pkg::REG_CONFIG, DEF_CFG);
   endtask

   task automatic register_readback();
      reg_write(dma_pkg::REG_STRIDE, 32'h0010_0004);
      reg_write(dma_pkg::REG_COUNT, 32'd5);
      reg_write(dma_pkg::REG_SRCADDR, 32'h1000_0040);
      reg_write(dma_pkg::REG_SRCADDR64, 32'ha5a5_0001);
      reg_write(dma_pkg::REG_DSTADDR, 32'h2000_0080);
      reg_write(dma_pkg::REG_DSTADDR64, 32'h5a5a_0002);
      reg_write(dma_pkg::REG_CONFIG, 32'h0000_0070);   // irqmode and datamode, no enable
      reg_read(dma_pkg::REG_STRIDE, 32'h0010_0004);
      reg_read(dma_pkg::REG_COUNT, 32'd5);
      reg_read(dma_pkg::REG_SRCADDR, 32'h1000_0040);
      reg_read(dma_pkg::REG_SRCADDR64, 32'ha5a5_0001);
      reg_read(dma_pkg::REG_DSTADDR, 32'h2000_0080);
      reg_read(dma_pkg::REG_DSTADDR64, 32'h5a5a_0002);
      reg_read(dma_pkg::REG_CONFIG, 32'h0000_0070);
   endtask

   task automatic transfer_sequence();
      run_transfer(6, 32'h0000_1000, 32'h0004_0000, 32'h0008_0004, 32'h51);
      await_irq();
      drain_requests();
      check(128'(irq), 128'(1'b1), "irq at end of transfer");
      check_final(6, 32'h0000_1000, 32'h0004_0000, 32'h0008_0004);
   endtask

   task automatic backpressure_transfer();
      bp_on = 1'b1;
      transfer_sequence();   // same packets expected under stalls
      bp_on = 1'b0;
   endtask

   task automatic readback_mid_transfer();
      bp_on = 1'b1;
      run_transfer(10, 32'h0000_3000, 32'h5000_0000, 32'h0020_0010, 32'h71);
      reg_read(dma_pkg::REG_CONFIG, 32'h71);   // engine still running
      reg_read(dma_pkg::REG_STRIDE, 32'h0020_0010);
      await_irq();
      drain_requests();
      check_final(10, 32'h0000_3000, 32'h5000_0000, 32'h0020_0010);
      reg_write(dma_pkg::REG_CONFIG, 32'h10);   // irqmode kept, engine off
      check(128'(irq), 128'(1'b0), "irq after config write");
      reg_read(dma_pkg::REG_STATUS, 32'(dma_pkg::ST_IDLE));
      bp_on = 1'b0;
   endtask

   task automatic transfer_without_irq();
      run_transfer(3, 32'h0000_0100, 32'h0000_0800, 32'h0004_0004, 32'h41);
      drain_requests();
      check(128'(irq), 128'(1'b0), "irq with irqmode clear");
      check_final(3, 32'h0000_0100, 32'h0000_0800, 32'h0004_0004);
      reg_write(dma_pkg::REG_CONFIG, 32'h0);
      reg_read(dma_pkg::REG_STATUS, 32'(dma_pkg::ST_IDLE));
   endtask

   initial begin
      errors        = 0;
      checks        = 0;
      reads         = 0;
      bp_on         = 1'b0;
      lcg_state     = 32'd61;
      nreset        = 1'b0;
      reg_access_in = 1'b0;
      reg_packet_in = '0;
      wait_in       = 1'b0;
      fork
         collect_packets();
         drive_wait();
      join_none
      repeat (5) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      reset_values();
      register_readback();
      transfer_sequence();
      backpressure_transfer();
      readback_mid_transfer();
      transfer_without_irq();
      if (req_q.size() != 0 || rsp_q.size() != 0) begin
         errors++;
         $display("some expected packets never left the DUT");
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== compile.f ====
rtl/mesh_pkg.sv
rtl/dma_pkg.sv
rtl/mesh_decode.sv
rtl/dma_regs.sv
rtl/dma_engine.sv
rtl/mesh_issue.sv
rtl/dma_top.sv
dv/dma_tb.sv

// ==== Makefile ====
# Verilator build and run of the dma testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module dma_tb -Mdir obj_dir -o dma_sim
	./obj_dir/dma_sim | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
